//--- include/bomb_consts.svh
// ##################################################
// game constants shared by the RTL and the testbench
// pull in with `include "bomb_consts.svh" (include/ on the path)
// ##################################################
`ifndef BOMB_CONSTS_SVH
`define BOMB_CONSTS_SVH

// game size
`define BOMB_PANELS      3          // wire panels on the bomb
`define BOMB_MAX_WIRES   6          // wire slots per panel
`define BOMB_MIN_WIRES   3          // fewest wires a panel shows
`define BOMB_MAX_STRIKES 3          // strikes that set off the bomb

`define BOMB_LFSR_SEED   16'hACE1   // layout lfsr start value, never zero

// one-hot button codes, sent with a one-cycle strobe
`define BTN_SELECT       6'b000001  // start game / cut wire
`define BTN_UP           6'b000010
`define BTN_RIGHT        6'b000100
`define BTN_DOWN         6'b001000
`define BTN_LEFT         6'b010000
`define BTN_BACK         6'b100000  // accepted, no function
`define BTN_NONE         6'b000000

`endif

//--- hdl/bomb_pkg.sv
// ##################################################
// types of the wire game: game state and wire colours
// referenced by scoped name, bomb_pkg::type
// ##################################################
`include "bomb_consts.svh"

package bomb_pkg;

    // overall game flow
    typedef enum logic [1:0] {
        MENU = 2'd0,                // waiting for select
        PLAY = 2'd1,                // panels live
        LOST = 2'd2,                // strike limit hit
        WON  = 2'd3                 // every panel solved
    } game_state_e;

    // colour codes, same order the rule engine counts them
    typedef enum logic [2:0] {
        RED    = 3'd0,
        WHITE  = 3'd1,
        YELLOW = 3'd2,
        BLUE   = 3'd3,
        BLACK  = 3'd4,
        NONE   = 3'd5               // empty slot
    } wire_color_e;

    // one panel worth of colours, slot 0 in the low bits
    typedef wire_color_e [`BOMB_MAX_WIRES-1:0] wire_colors_t;

endpackage

//--- hdl/wire_panel_if.sv
// ##################################################
// per-panel bundle: layout, cursor, cut strobe, result
// one instance per panel, built in bomb_wires_top
// ##################################################
`timescale 1ns/1ps
`include "bomb_consts.svh"

interface wire_panel_if;

    logic [2:0]                wire_num;     // wires present, 3..6
    bomb_pkg::wire_colors_t    wire_color;   // colour per slot
    logic [2:0]                wire_pos;     // cursor slot
    logic                      cut;          // cut strobe at wire_pos
    logic [`BOMB_MAX_WIRES-1:0] wire_status; // 1 = already cut
    logic                      clear;        // right wire cut
    logic                      error;        // wrong wire cut

    modport layout (output wire_num, wire_color);
    modport nav    (output wire_pos, cut, input wire_num);
    modport panel  (input wire_num, wire_color, wire_pos, cut,
                    output wire_status, clear, error);
    modport status (input clear, error);

endinterface

//--- hdl/wire_layout_gen.sv
// ##################################################
// random wire layouts from a free-running 16-bit lfsr
// every panel reloads on the activate strobe
// ##################################################
`timescale 1ns/1ps
`include "bomb_consts.svh"

module wire_layout_gen (
    input  logic         clk,
    input  logic         nrst,
    input  logic         activate,                  // game start strobe
    wire_panel_if.layout panels [`BOMB_PANELS]
);

    logic [15:0] lfsr;                      // galois state
    logic [31:0] rnd [`BOMB_PANELS];        // random word per panel

    // advance a galois lfsr n steps, x^16+x^14+x^13+x^11+1
    function automatic logic [15:0] lfsr_adv(input logic [15:0] s, input int n);
        logic [15:0] r;
        r = s;
        for (int k = 0; k < n; k++) begin
            r = r[0] ? ((r >> 1) ^ 16'hB400) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (!nrst) begin
            lfsr <= `BOMB_LFSR_SEED;
        end else begin
            lfsr <= lfsr_adv(lfsr, 1);      // steps every cycle, game or not
        end
    end

    // panel 0 sees the live value, later panels a further-stepped one
    always_comb begin
        logic [15:0] s;
        s = lfsr;
        for (int p = 0; p < `BOMB_PANELS; p++) begin
            rnd[p][15:0]  = s;
            s             = lfsr_adv(s, 16);
            rnd[p][31:16] = s;
            s             = lfsr_adv(s, 16);
        end
    end

    for (genvar p = 0; p < `BOMB_PANELS; p++) begin : g_panel
        logic [2:0]             num_nxt;
        bomb_pkg::wire_colors_t col_nxt;

        always_comb begin
            num_nxt = 3'(`BOMB_MIN_WIRES) + {1'b0, rnd[p][1:0]};   // 3..6
            for (int i = 0; i < `BOMB_MAX_WIRES; i++) begin
                logic [2:0] v;
                v = rnd[p][2 + 3*i +: 3];
                if (i >= int'(num_nxt)) begin
                    col_nxt[i] = bomb_pkg::NONE;                    // no wire here
                end else if (v > 3'd4) begin
                    col_nxt[i] = bomb_pkg::wire_color_e'(v - 3'd5); // 5..7 fold onto red..yellow
                end else begin
                    col_nxt[i] = bomb_pkg::wire_color_e'(v);
                end
            end
        end

        always_ff @(posedge clk) begin
            if (!nrst) begin
                panels[p].wire_num   <= 3'(`BOMB_MIN_WIRES);
                panels[p].wire_color <= {`BOMB_MAX_WIRES{bomb_pkg::NONE}};
            end else if (activate) begin
                panels[p].wire_num   <= num_nxt;
                panels[p].wire_color <= col_nxt;
            end
        end

        // navigator and detector both rely on this range
        a_num_range: assert property (@(posedge clk) disable iff (!nrst)
            panels[p].wire_num >= 3'(`BOMB_MIN_WIRES)
            && panels[p].wire_num <= 3'(`BOMB_MAX_WIRES));
    end

endmodule

//--- hdl/panel_navigator.sv
// ##################################################
// cursor control: panel select, wire cursor, cut strobe
// acts on button strobes only while the game is in PLAY
// ##################################################
`timescale 1ns/1ps
`include "bomb_consts.svh"

module panel_navigator (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  strobe,       // one cycle per press
    input  logic [5:0]            button,       // one-hot code
    input  bomb_pkg::game_state_e game_state,
    output logic [1:0]            panel_sel,    // selected panel
    wire_panel_if.nav             panels [`BOMB_PANELS]
);

    logic       playing;                        // cursor live
    logic [1:0] sel_nxt;                        // panel after left/right
    logic       side;                           // left or right pressed

    assign playing = (game_state == bomb_pkg::PLAY);
    assign side    = (button == `BTN_RIGHT) || (button == `BTN_LEFT);

    always_comb begin
        sel_nxt = panel_sel;
        if (button == `BTN_RIGHT) begin
            sel_nxt = (panel_sel == 2'(`BOMB_PANELS - 1)) ? 2'd0 : panel_sel + 2'd1;
        end else if (button == `BTN_LEFT) begin
            sel_nxt = (panel_sel == 2'd0) ? 2'(`BOMB_PANELS - 1) : panel_sel - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst || !playing) begin
            panel_sel <= 2'd0;                  // back to panel 0 outside play
        end else if (strobe) begin
            panel_sel <= sel_nxt;
        end
    end

    for (genvar p = 0; p < `BOMB_PANELS; p++) begin : g_panel
        // cut goes to the selected panel only, same cycle as the press
        assign panels[p].cut = playing && strobe && (button == `BTN_SELECT)
                               && (panel_sel == 2'(p));

        always_ff @(posedge clk) begin
            if (!nrst || !playing) begin
                panels[p].wire_pos <= 3'd0;
            end else if (strobe) begin
                if (side && sel_nxt == 2'(p)) begin
                    panels[p].wire_pos <= 3'd0;         // entering panel starts at wire 0
                end else if (panel_sel == 2'(p)) begin
                    case (button)
                        `BTN_DOWN: if (panels[p].wire_pos < panels[p].wire_num - 3'd1)
                            panels[p].wire_pos <= panels[p].wire_pos + 3'd1;
                        `BTN_UP: if (panels[p].wire_pos != 3'd0)
                            panels[p].wire_pos <= panels[p].wire_pos - 3'd1;
                        `BTN_BACK: ;                    // no function
                        default: ;
                    endcase
                end
            end
        end

        // cursor must stay on a real wire, layout comes from wire_layout_gen
        a_pos_range: assert property (@(posedge clk) disable iff (!nrst)
            panels[p].wire_pos < panels[p].wire_num);
    end

endmodule

//--- hdl/wire_cut_detector.sv
// ##################################################
// rule engine for one panel: picks the right wire by the
// colour rules, tracks cut wires, flags clear or error
// ##################################################
`timescale 1ns/1ps
`include "bomb_consts.svh"

module wire_cut_detector (
    input  logic        clk,
    input  logic        nrst,
    input  logic        activate,           // new game, wipe cut status
    wire_panel_if.panel panel
);

    logic [2:0]            n_red, n_white, n_yellow, n_blue, n_black;  // colour counts
    logic [2:0]            last_idx;                    // slot of last wire
    bomb_pkg::wire_color_e last_col;
    logic [2:0]            right_wire;                  // wire to cut
    logic                  fresh;                       // cut on an uncut wire

    assign last_idx = panel.wire_num - 3'd1;
    assign last_col = panel.wire_color[last_idx];

    always_comb begin
        n_red    = 3'd0;
        n_white  = 3'd0;
        n_yellow = 3'd0;
        n_blue   = 3'd0;
        n_black  = 3'd0;
        for (int i = 0; i < `BOMB_MAX_WIRES; i++) begin
            case (panel.wire_color[i])                  // empty slots are NONE, skipped
                bomb_pkg::RED:    n_red    = n_red + 3'd1;
                bomb_pkg::WHITE:  n_white  = n_white + 3'd1;
                bomb_pkg::YELLOW: n_yellow = n_yellow + 3'd1;
                bomb_pkg::BLUE:   n_blue   = n_blue + 3'd1;
                bomb_pkg::BLACK:  n_black  = n_black + 3'd1;
                default: ;
            endcase
        end
    end

    // classic wire table, one branch per wire count
    always_comb begin
        right_wire = 3'd0;
        case (panel.wire_num)
            3'd3: begin
                if (n_red == 3'd0) begin
                    right_wire = 3'd1;                  // no red, second wire
                end else if (last_col == bomb_pkg::WHITE) begin
                    right_wire = last_idx;              // last is white, last wire
                end else if (n_blue > 3'd1) begin
                    for (int i = 0; i < 3; i++) begin   // last blue wire
                        if (panel.wire_color[i] == bomb_pkg::BLUE) right_wire = 3'(i);
                    end
                end else begin
                    right_wire = last_idx;
                end
            end
            3'd4: begin
                if (n_red > 3'd1) begin
                    for (int i = 0; i < 4; i++) begin   // last red wire
                        if (panel.wire_color[i] == bomb_pkg::RED) right_wire = 3'(i);
                    end
                end else if (n_red == 3'd0 && last_col == bomb_pkg::YELLOW) begin
                    right_wire = 3'd0;                  // no red, yellow last, first wire
                end else if (n_blue == 3'd1) begin
                    right_wire = 3'd0;                  // single blue, first wire
                end else if (n_yellow > 3'd1) begin
                    right_wire = last_idx;
                end else begin
                    right_wire = 3'd1;
                end
            end
            3'd5: begin
                if (last_col == bomb_pkg::BLACK) begin
                    right_wire = 3'd3;                  // black last, fourth wire
                end else if (n_red == 3'd1 && n_yellow > 3'd1) begin
                    right_wire = 3'd0;
                end else if (n_black == 3'd0) begin
                    right_wire = 3'd1;
                end else begin
                    right_wire = 3'd0;
                end
            end
            3'd6: begin
                if (n_yellow == 3'd0) begin
                    right_wire = 3'd2;                  // no yellow, third wire
                end else if (n_yellow == 3'd1 && n_white > 3'd1) begin
                    right_wire = 3'd3;
                end else if (n_red == 3'd0) begin
                    right_wire = last_idx;
                end else begin
                    right_wire = 3'd3;
                end
            end
            default: right_wire = 3'd0;
        endcase
    end

    // recut of a cut wire is ignored
    assign fresh       = panel.cut && !panel.wire_status[panel.wire_pos];
    assign panel.clear = fresh && (panel.wire_pos == right_wire);
    assign panel.error = fresh && (panel.wire_pos != right_wire);

    always_ff @(posedge clk) begin
        if (!nrst || activate) begin
            panel.wire_status <= '0;
        end else if (fresh) begin
            panel.wire_status[panel.wire_pos] <= 1'b1;
        end
    end

    // a fresh cut reads back as cut on the next cycle
    a_cut_stored: assert property (@(posedge clk) disable iff (!nrst)
        fresh |=> panel.wire_status[$past(panel.wire_pos)]);

endmodule

//--- hdl/bomb_status.sv
// ##################################################
// game fsm: menu, play, lost, won; strike counter and
// per-panel solved flags fed by the panel detectors
// ##################################################
`timescale 1ns/1ps
`include "bomb_consts.svh"

module bomb_status (
    input  logic                    clk,
    input  logic                    nrst,
    input  logic                    strobe,
    input  logic [5:0]              button,
    wire_panel_if.status            panels [`BOMB_PANELS],
    output logic                    activate,       // one-cycle game start
    output bomb_pkg::game_state_e   game_state,
    output logic [1:0]              strikes,
    output logic [`BOMB_PANELS-1:0] panel_solved
);

    logic [`BOMB_PANELS-1:0] clr_v;         // clear per panel
    logic [`BOMB_PANELS-1:0] err_v;         // error per panel
    logic [`BOMB_PANELS-1:0] solved_nxt;
    logic [1:0]              strikes_nxt;

    for (genvar p = 0; p < `BOMB_PANELS; p++) begin : g_panel
        assign clr_v[p] = panels[p].clear;
        assign err_v[p] = panels[p].error;
    end

    // select from menu, lost or won starts a fresh game
    assign activate    = strobe && (button == `BTN_SELECT)
                         && (game_state != bomb_pkg::PLAY);
    assign strikes_nxt = strikes + 2'(|err_v);  // solved panels still strike
    assign solved_nxt  = panel_solved | clr_v;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            game_state   <= bomb_pkg::MENU;
            strikes      <= 2'd0;
            panel_solved <= '0;
        end else if (activate) begin
            game_state   <= bomb_pkg::PLAY;
            strikes      <= 2'd0;
            panel_solved <= '0;
        end else if (game_state == bomb_pkg::PLAY) begin
            strikes      <= strikes_nxt;
            panel_solved <= solved_nxt;
            if (strikes_nxt == 2'(`BOMB_MAX_STRIKES)) begin
                game_state <= bomb_pkg::LOST;           // loss wins over a last solve
            end else if (&solved_nxt) begin
                game_state <= bomb_pkg::WON;
            end
        end
    end

    // a lost game means the strike count sits exactly at the limit
    a_strike_limit: assert property (@(posedge clk) disable iff (!nrst)
        (game_state == bomb_pkg::LOST) |-> (strikes == 2'(`BOMB_MAX_STRIKES)));

endmodule

//--- hdl/bomb_wires_top.sv
// ##################################################
// top of the wire game: layout, cursor, detectors, fsm
// panel bundles leave as flat per-panel packed arrays
// ##################################################
`timescale 1ns/1ps
`include "bomb_consts.svh"

module bomb_wires_top (
    input  logic                                     clk,
    input  logic                                     nrst,
    input  logic                                     strobe,
    input  logic [5:0]                               button,
    output bomb_pkg::game_state_e                    game_state,
    output logic [1:0]                               strikes,
    output logic [1:0]                               panel_sel,
    output logic [`BOMB_PANELS-1:0]                  panel_solved,
    output logic [`BOMB_PANELS-1:0][2:0]             wire_pos,
    output logic [`BOMB_PANELS-1:0][2:0]             wire_num,
    output bomb_pkg::wire_colors_t [`BOMB_PANELS-1:0] wire_color,
    output logic [`BOMB_PANELS-1:0][`BOMB_MAX_WIRES-1:0] wire_status
);

    logic activate;                         // start strobe from the fsm

    wire_panel_if pif [`BOMB_PANELS] ();    // one bundle per panel

    wire_layout_gen u_layout (
        .clk      (clk),
        .nrst     (nrst),
        .activate (activate),
        .panels   (pif)
    );

    panel_navigator u_nav (
        .clk        (clk),
        .nrst       (nrst),
        .strobe     (strobe),
        .button     (button),
        .game_state (game_state),
        .panel_sel  (panel_sel),
        .panels     (pif)
    );

    bomb_status u_status (
        .clk          (clk),
        .nrst         (nrst),
        .strobe       (strobe),
        .button       (button),
        .panels       (pif),
        .activate     (activate),
        .game_state   (game_state),
        .strikes      (strikes),
        .panel_solved (panel_solved)
    );

    for (genvar p = 0; p < `BOMB_PANELS; p++) begin : g_panel
        wire_cut_detector u_det (
            .clk      (clk),
            .nrst     (nrst),
            .activate (activate),
            .panel    (pif[p])
        );

        assign wire_pos[p]    = pif[p].wire_pos;     // flatten for the outside
        assign wire_num[p]    = pif[p].wire_num;
        assign wire_color[p]  = pif[p].wire_color;
        assign wire_status[p] = pif[p].wire_status;
    end

endmodule

//--- tb/tb_bomb_wires.sv
// ##################################################
// testbench for bomb_wires_top: runs a step table of
// starts, moves and cuts against a model of the wire rules
// ##################################################
`timescale 1ns/1ps
`include "bomb_consts.svh"

module tb_bomb_wires;

    localparam int NP       = `BOMB_PANELS;
    localparam int NSTEPS   = 17;
    localparam int WAIT_MAX = 16;                   // cycles or presses per wait

    localparam logic [2:0] A_START = 3'd0, A_MOVE_TO = 3'd1, A_CUT_RIGHT = 3'd2;
    localparam logic [2:0] A_CUT_WRONG = 3'd3, A_RECUT = 3'd4, A_CHECK_STATE = 3'd5;

    // row = action, target (panel or state), strikes expected after the row
    localparam logic [7:0] STEPS [NSTEPS] = '{
        {A_START,       3'd0, 2'd0},
        {A_MOVE_TO,     3'd2, 2'd0},
        {A_MOVE_TO,     3'd0, 2'd0},                // wraps 2 -> 0
        {A_CUT_WRONG,   3'd0, 2'd1},
        {A_RECUT,       3'd0, 2'd1},                // same wire again, no strike
        {A_CUT_RIGHT,   3'd0, 2'd1},
        {A_CUT_RIGHT,   3'd1, 2'd1},
        {A_CUT_WRONG,   3'd2, 2'd2},
        {A_CUT_RIGHT,   3'd2, 2'd2},
        {A_CHECK_STATE, 3'(bomb_pkg::WON), 2'd2},
        {A_START,       3'd0, 2'd0},
        {A_CUT_WRONG,   3'd0, 2'd1},
        {A_CUT_WRONG,   3'd1, 2'd2},
        {A_CUT_WRONG,   3'd2, 2'd3},
        {A_CHECK_STATE, 3'(bomb_pkg::LOST), 2'd3},
        {A_START,       3'd0, 2'd0},                // restart after a loss
        {A_CHECK_STATE, 3'(bomb_pkg::PLAY), 2'd0}
    };

    logic                                 clk;
    logic                                 nrst;
    logic                                 strobe;
    logic [5:0]                           button;
    bomb_pkg::game_state_e                game_state;
    logic [1:0]                           strikes;
    logic [1:0]                           panel_sel;
    logic [NP-1:0]                        panel_solved;
    logic [NP-1:0][2:0]                   wire_pos;
    logic [NP-1:0][2:0]                   wire_num;
    bomb_pkg::wire_colors_t [NP-1:0]      wire_color;
    logic [NP-1:0][`BOMB_MAX_WIRES-1:0]   wire_status;

    integer          seed = 32'h66db_659c;          // wrong-wire picks
    int              errors = 0;
    int              last_p;                        // last wrong cut, for recut
    int              last_w;
    logic [NP*21-1:0] prev_layout;                  // nums + colours of the last game

    bomb_wires_top u_dut (
        .clk          (clk),
        .nrst         (nrst),
        .strobe       (strobe),
        .button       (button),
        .game_state   (game_state),
        .strikes      (strikes),
        .panel_sel    (panel_sel),
        .panel_solved (panel_solved),
        .wire_pos     (wire_pos),
        .wire_num     (wire_num),
        .wire_color   (wire_color),
        .wire_status  (wire_status)
    );

    always #20 clk = ~clk;                          // 40 ns period

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // one strobed press, driven 5 ns after the edge, returns 5 ns after the next edge
    task automatic press(input logic [5:0] b);
        strobe = 1'b1;
        button = b;
        @(posedge clk);
        #5;
        strobe = 1'b0;
        button = `BTN_NONE;
    endtask

    task automatic wait_state(input bomb_pkg::game_state_e exp);
        int n;
        n = 0;
        while (game_state != exp && n < WAIT_MAX) begin
            @(posedge clk);
            #5;
            n++;
        end
        assert (game_state == exp) else begin
            $display("timeout: game stayed in %s instead of reaching %s",
                     game_state.name(), exp.name());
            errors++;
        end
    endtask

    task automatic goto_panel(input int p);
        int n;
        int prev;
        n = 0;
        while (panel_sel != 2'(p) && n < WAIT_MAX) begin
            prev = int'(panel_sel);
            press(`BTN_RIGHT);
            check_val("panel_sel", panel_sel, (prev + 1) % NP);     // wraps at the last panel
            check_val("wire_pos", wire_pos[panel_sel], 0);          // entering panel starts at 0
            n++;
        end
        assert (panel_sel == 2'(p)) else begin
            $display("timeout: cursor never reached panel %0d", p);
            errors++;
        end
    endtask

    task automatic goto_wire(input int w);
        int n;
        int p;
        n = 0;
        p = int'(panel_sel);
        while (int'(wire_pos[p]) != w && n < WAIT_MAX) begin
            press((int'(wire_pos[p]) < w) ? `BTN_DOWN : `BTN_UP);
            n++;
        end
        assert (int'(wire_pos[p]) == w) else begin
            $display("timeout: wire cursor on panel %0d never reached wire %0d", p, w);
            errors++;
        end
    endtask

    // right wire by the classic table, serial number rules left out
    function automatic int right_wire(input int num, input bomb_pkg::wire_colors_t col);
        int cnt [5];
        int last_of [5];                            // last slot holding each colour
        int c;
        bomb_pkg::wire_color_e last;
        for (int k = 0; k < 5; k++) begin
            cnt[k] = 0;
            last_of[k] = 0;
        end
        for (int i = 0; i < num; i++) begin
            c = int'(col[i]);
            if (c < 5) begin
                cnt[c]++;
                last_of[c] = i;
            end
        end
        last = col[num-1];
        case (num)
            3: begin
                if (cnt[bomb_pkg::RED] == 0) return 1;
                if (last == bomb_pkg::WHITE) return num - 1;
                if (cnt[bomb_pkg::BLUE] > 1) return last_of[bomb_pkg::BLUE];
                return num - 1;
            end
            4: begin
                if (cnt[bomb_pkg::RED] > 1) return last_of[bomb_pkg::RED];
                if (last == bomb_pkg::YELLOW && cnt[bomb_pkg::RED] == 0) return 0;
                if (cnt[bomb_pkg::BLUE] == 1) return 0;
                if (cnt[bomb_pkg::YELLOW] > 1) return num - 1;
                return 1;
            end
            5: begin
                if (last == bomb_pkg::BLACK) return 3;
                if (cnt[bomb_pkg::RED] == 1 && cnt[bomb_pkg::YELLOW] > 1) return 0;
                if (cnt[bomb_pkg::BLACK] == 0) return 1;
                return 0;
            end
            default: begin                          // six wires
                if (cnt[bomb_pkg::YELLOW] == 0) return 2;
                if (cnt[bomb_pkg::YELLOW] == 1 && cnt[bomb_pkg::WHITE] > 1) return 3;
                if (cnt[bomb_pkg::RED] == 0) return num - 1;
                return 3;
            end
        endcase
    endfunction

    task automatic pick_wrong(input int p, output int w);
        int          cand [$];
        int          good;
        int unsigned r;
        good = right_wire(int'(wire_num[p]), wire_color[p]);
        for (int i = 0; i < int'(wire_num[p]); i++) begin
            if (i != good && !wire_status[p][i]) cand.push_back(i);
        end
        w = 0;
        assert (cand.size() > 0) else begin
            $display("no uncut wrong wire left on panel %0d", p);
            errors++;
        end
        if (cand.size() > 0) begin
            r = $random(seed);
            w = cand[r % cand.size()];
        end
    endtask

    task automatic check_start();
        logic [NP*21-1:0] layout;
        layout = {wire_num, wire_color};
        check_val("game_state", game_state, bomb_pkg::PLAY);        // one cycle after select
        check_val("strikes", strikes, 0);
        check_val("panel_solved", panel_solved, 0);
        check_val("panel_sel", panel_sel, 0);
        assert (layout != prev_layout) else begin
            $display("new game kept the layout of the previous one");
            errors++;
        end
        prev_layout = layout;
        for (int p = 0; p < NP; p++) begin
            assert (wire_num[p] >= 3'd3 && wire_num[p] <= 3'd6) else begin
                $display("wire_num of panel %0d is %0d, outside 3..6", p, wire_num[p]);
                errors++;
            end
            for (int i = 0; i < `BOMB_MAX_WIRES; i++) begin
                if (i < int'(wire_num[p])) begin
                    assert (wire_color[p][i] <= bomb_pkg::BLACK) else begin
                        $display("panel %0d slot %0d holds no real colour", p, i);
                        errors++;
                    end
                end else begin
                    check_val($sformatf("wire_color[%0d][%0d]", p, i), wire_color[p][i],
                              bomb_pkg::NONE);
                end
            end
            check_val($sformatf("wire_status[%0d]", p), wire_status[p], 0);
            check_val($sformatf("wire_pos[%0d]", p), wire_pos[p], 0);
        end
    endtask

    task automatic run_step(input logic [7:0] row);
        int                      tgt;
        int                      w;
        int                      left_p;
        logic [`BOMB_MAX_WIRES-1:0] st_before;
        logic [NP-1:0]           solved_before;
        tgt = int'(row[4:2]);
        case (row[7:5])
            A_START: begin
                press(`BTN_SELECT);
                check_start();
            end
            A_MOVE_TO: begin
                goto_panel(tgt);
                goto_wire(0);
                press(`BTN_UP);
                check_val("wire_pos at top", wire_pos[tgt], 0);
                repeat (`BOMB_MAX_WIRES) press(`BTN_DOWN);           // more than enough to saturate
                check_val("wire_pos at bottom", wire_pos[tgt], wire_num[tgt] - 3'd1);
                left_p = (tgt + NP - 1) % NP;                        // left wraps below panel 0
                press(`BTN_LEFT);
                check_val("panel_sel after left", panel_sel, left_p);
                check_val("wire_pos after left", wire_pos[left_p], 0);
                press(`BTN_RIGHT);
                check_val("panel_sel after right", panel_sel, tgt);
                check_val("wire_pos after right", wire_pos[tgt], 0);
            end
            A_CUT_RIGHT: begin
                goto_panel(tgt);
                w = right_wire(int'(wire_num[tgt]), wire_color[tgt]);
                goto_wire(w);
                press(`BTN_SELECT);
                check_val("wire_status bit", wire_status[tgt][w], 1);
                check_val("panel_solved bit", panel_solved[tgt], 1);
            end
            A_CUT_WRONG: begin
                goto_panel(tgt);
                pick_wrong(tgt, w);
                goto_wire(w);
                press(`BTN_SELECT);
                check_val("wire_status bit", wire_status[tgt][w], 1);
                check_val("panel_solved bit", panel_solved[tgt], 0);
                last_p = tgt;
                last_w = w;
            end
            A_RECUT: begin
                goto_panel(last_p);
                goto_wire(last_w);
                st_before     = wire_status[last_p];
                solved_before = panel_solved;
                press(`BTN_SELECT);
                check_val("wire_status", wire_status[last_p], st_before);
                check_val("panel_solved", panel_solved, solved_before);
            end
            default: wait_state(bomb_pkg::game_state_e'(row[3:2]));   // check state
        endcase
        check_val("strikes", strikes, row[1:0]);
    endtask

    initial begin
        int err_before;
        clk    = 1'b0;
        nrst   = 1'b0;
        strobe = 1'b0;
        button = `BTN_NONE;
        last_p = 0;
        last_w = 0;
        repeat (10) @(posedge clk);
        #5;
        nrst = 1'b1;
        err_before = errors;
        check_val("game_state", game_state, bomb_pkg::MENU);
        check_val("strikes", strikes, 0);
        check_val("panel_solved", panel_solved, 0);
        for (int p = 0; p < NP; p++) begin
            check_val($sformatf("wire_num[%0d]", p), wire_num[p], 3);
            check_val($sformatf("wire_color[%0d]", p), wire_color[p],
                      {`BOMB_MAX_WIRES{bomb_pkg::NONE}});
        end
        prev_layout = {wire_num, wire_color};
        $display("test reset: %s", (errors == err_before) ? "ok" : "failed");
        for (int i = 0; i < NSTEPS; i++) begin
            err_before = errors;
            run_step(STEPS[i]);
            $display("test %0d action %0d target %0d: %s", i, STEPS[i][7:5], STEPS[i][4:2],
                     (errors == err_before) ? "ok" : "failed");
        end
        $display("tests run: %0d, errors: %0d", NSTEPS + 1, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #200000;                                    // far beyond a normal run
        $display("timeout: simulation ran past its time limit");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- bomb_wires.f
+incdir+include
hdl/bomb_pkg.sv
hdl/wire_panel_if.sv
hdl/wire_layout_gen.sv
hdl/panel_navigator.sv
hdl/wire_cut_detector.sv
hdl/bomb_status.sv
hdl/bomb_wires_top.sv
tb/tb_bomb_wires.sv

//--- Makefile
# Verilator build for the wire game testbench
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_bomb_wires
FILELIST  ?= bomb_wires.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
